/* common/rv32_pkg.sv */
// Shared definitions for the RV32I pipelined core
// Opcodes, ALU operation codes, instruction format views
// Decoded controls and the pipeline register layouts

`default_nettype none

package rv32_pkg;

  localparam int xlen = 32;

  // Base opcodes of the supported subset
  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_lui   = 7'b0110111;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll
  } alu_op_t;

  // Where an execute operand comes from
  typedef enum logic [1:0] {
    fwd_none,  // register file value captured in decode
    fwd_mem,
    fwd_wb
  } fwd_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One instruction word in four field layouts
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } instr_u;

  typedef struct packed {
    logic    reg_write;
    logic    mem_write;
    logic    mem_to_reg;
    logic    use_imm;   // operand B from the immediate
    logic    zero_a;    // lui adds its immediate to zero
    alu_op_t alu_op;
    logic    is_load;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    alu_out;   // also the memory address
    word_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     mem_to_reg;
    reg_idx_t rd;
    word_t    alu_out;
    word_t    load_data;
  } mem_wb_t;

  typedef struct packed {
    logic  write;  // single cycle strobe
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

/* execute/alu.sv */
// Integer ALU for the execute stage
// add, sub, and, or, xor and shift left logical

`timescale 1ns/1ps
`default_nettype none

module alu
  import rv32_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // only the low bits count

  always_comb
  begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_sll: result = a << shamt;
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

/* execute/hazard_unit.sv */
// Hazard detection
// Forwarding selects for both execute operands
// Load-use stall between execute and decode

`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import rv32_pkg::*;
(
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  mem_wb,
  input  reg_idx_t dec_rs1,
  input  reg_idx_t dec_rs2,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output logic     stall
);

  logic mem_writes;
  logic wb_writes;
  logic load_in_ex;

  // x0 results are never forwarded
  assign mem_writes = ex_mem.valid & ex_mem.ctrl.reg_write & (ex_mem.rd != 5'd0);
  assign wb_writes  = mem_wb.valid & mem_wb.reg_write & (mem_wb.rd != 5'd0);

  // Memory stage holds the younger result, so it wins
  function automatic fwd_sel_t fwd_select(reg_idx_t idx);
    if (mem_writes && ex_mem.rd == idx)
      return fwd_mem;
    else if (wb_writes && mem_wb.rd == idx)
      return fwd_wb;
    else
      return fwd_none;
  endfunction

  always_comb
  begin
    fwd_a = fwd_select(id_ex.rs1);
    fwd_b = fwd_select(id_ex.rs2);
  end

  assign load_in_ex = id_ex.valid & id_ex.ctrl.is_load & (id_ex.rd != 5'd0);

  // Load data arrives in writeback so one bubble is enough
  assign stall = load_in_ex && (id_ex.rd == dec_rs1 || id_ex.rd == dec_rs2);

endmodule

`default_nettype wire

/* decode/instr_decoder.sv */
// Instruction decoder
// Main control decode, ALU operation decode and immediate generation

`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import rv32_pkg::*;
(
  input  instr_u instr,
  output ctrl_t  ctrl,
  output word_t  imm
);

  alu_op_t alu_sel;
  logic    alu_ok;  // function code is one we implement

  // ALU decode from funct7 and funct3
  always_comb
  begin
    alu_sel = alu_add;
    alu_ok  = 1'b0;
    if (instr.r.opcode == op_reg)
    begin
      alu_ok = 1'b1;
      case ({instr.r.funct7, instr.r.funct3})
        10'b0000000_000: alu_sel = alu_add;
        10'b0100000_000: alu_sel = alu_sub;
        10'b0000000_111: alu_sel = alu_and;
        10'b0000000_110: alu_sel = alu_or;
        10'b0000000_100: alu_sel = alu_xor;
        10'b0000000_001: alu_sel = alu_sll;
        default:         alu_ok  = 1'b0;
      endcase
    end
    else
    begin
      alu_ok = 1'b1;
      case (instr.i.funct3)
        3'b000:  alu_sel = alu_add;
        3'b111:  alu_sel = alu_and;
        3'b110:  alu_sel = alu_or;
        3'b100:  alu_sel = alu_xor;
        3'b001:
        begin
          alu_sel = alu_sll;
          alu_ok  = (instr.r.funct7 == 7'b0000000);  // slli shamt is 5 bits
        end
        default: alu_ok = 1'b0;
      endcase
    end
  end

  // Main decode with anything unknown falling through as a no-op
  always_comb
  begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    imm = '0;
    case (instr.r.opcode)
      op_reg:
      begin
        ctrl.reg_write = alu_ok;
        ctrl.alu_op    = alu_sel;
      end
      op_imm:
      begin
        ctrl.reg_write = alu_ok;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = alu_sel;
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      op_load:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.use_imm    = 1'b1;
        ctrl.is_load    = 1'b1;
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      op_store:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      end
      op_lui:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.zero_a    = 1'b1;
        imm = {instr.u.imm, 12'b0};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
// Integer register file
// 31 writable registers, x0 reads zero, same-cycle writes bypass to reads

`timescale 1ns/1ps
`default_nettype none

module reg_file
  import rv32_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  word_t regs [1:31];

  // Write-first read for the writeback to decode path
  function automatic word_t read_port(reg_idx_t idx);
    if (idx == 5'd0)
      return '0;
    else if (we && rd == idx)
      return rd_data;
    else
      return regs[idx];
  endfunction

  always_comb
  begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && rd != 5'd0)
      regs[rd] <= rd_data;
  end

endmodule

`default_nettype wire

/* hdl/rv32_core.sv */
// Five-stage RV32I integer core
// PC and fetch register, decode/execute/memory/writeback pipeline registers
// Operand forwarding muxes, data memory request and writeback select

`timescale 1ns/1ps
`default_nettype none

module rv32_core
  import rv32_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  output word_t     pc,
  input  word_t     inst,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata
);

  logic     if_valid;
  instr_u   if_instr;

  ctrl_t    dec_ctrl;
  word_t    dec_imm;
  logic     dec_active;
  reg_idx_t dec_rs1;
  reg_idx_t dec_rs2;
  word_t    rf_rs1_data;
  word_t    rf_rs2_data;

  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  mem_wb_t  mem_wb;

  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     stall;

  word_t    fwd_a_data;
  word_t    fwd_b_data;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;
  word_t    wb_data;

  // Pick the newest copy of an execute operand
  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
    case (sel)
      fwd_mem: return ex_mem.alu_out;
      fwd_wb:  return wb_data;
      default: return reg_val;
    endcase
  endfunction

  // Fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      if_valid <= 1'b0;
    else
      if_valid <= 1'b1;  // fetch never stops after reset
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      if_instr <= '0;
    else if (!stall)
      if_instr <= inst;
  end

  // Decode
  instr_decoder instr_decoder_i (
    .instr (if_instr),
    .ctrl  (dec_ctrl),
    .imm   (dec_imm)
  );

  // Unused source fields are masked to x0 so they never stall
  assign dec_active = if_valid & (dec_ctrl.reg_write | dec_ctrl.mem_write);
  assign dec_rs1 = (dec_active && !dec_ctrl.zero_a) ? if_instr.r.rs1 : 5'd0;
  assign dec_rs2 = (dec_active && (!dec_ctrl.use_imm || dec_ctrl.mem_write)) ?
                   if_instr.r.rs2 : 5'd0;

  reg_file reg_file_i (
    .clk      (clk),
    .reset    (reset),
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .we       (mem_wb.valid & mem_wb.reg_write),
    .rd       (mem_wb.rd),
    .rd_data  (wb_data)
  );

  hazard_unit hazard_unit_i (
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .dec_rs1 (dec_rs1),
    .dec_rs2 (dec_rs2),
    .fwd_a   (fwd_a),
    .fwd_b   (fwd_b),
    .stall   (stall)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else if (stall)
    begin
      id_ex.valid <= 1'b0;  // bubble behind the load
      id_ex.ctrl  <= '0;
    end
    else
      id_ex <= '{valid:    if_valid,
                 ctrl:     dec_ctrl,
                 rs1:      dec_rs1,
                 rs2:      dec_rs2,
                 rd:       if_instr.r.rd,
                 rs1_data: rf_rs1_data,
                 rs2_data: rf_rs2_data,
                 imm:      dec_imm};
  end

  // Execute
  always_comb
  begin
    fwd_a_data = fwd_mux(fwd_a, id_ex.rs1_data);
    fwd_b_data = fwd_mux(fwd_b, id_ex.rs2_data);
  end

  assign alu_a = id_ex.ctrl.zero_a ? '0 : fwd_a_data;
  assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b_data;

  alu alu_i (
    .a      (alu_a),
    .b      (alu_b),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_result)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
      ex_mem <= '{valid:      id_ex.valid,
                  ctrl:       id_ex.ctrl,
                  rd:         id_ex.rd,
                  alu_out:    alu_result,
                  store_data: fwd_b_data};  // store data sees forwarding too
  end

  // Memory
  assign dmem_req = '{write: ex_mem.valid & ex_mem.ctrl.mem_write,
                      addr:  ex_mem.alu_out,
                      wdata: ex_mem.store_data};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
      mem_wb <= '{valid:      ex_mem.valid,
                  reg_write:  ex_mem.ctrl.reg_write,
                  mem_to_reg: ex_mem.ctrl.mem_to_reg,
                  rd:         ex_mem.rd,
                  alu_out:    ex_mem.alu_out,
                  load_data:  dmem_rdata};
  end

  // Writeback
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_out;

endmodule

`default_nettype wire

/* tests/tb_ref_model.svh */
// Random program generator and architectural reference model
// Instruction encoders, source picker, program builder
// Reference ALU and one-instruction step of the model

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic word_t encode_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic word_t encode_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, logic [6:0] opcode);
  return {imm, rs1, f3, rd, opcode};
endfunction

// Store word with funct3 fixed at 010
function automatic word_t encode_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
endfunction

// Half the time a source is one of the last three destinations
function automatic reg_idx_t pick_src(reg_idx_t d1, reg_idx_t d2, reg_idx_t d3);
  case ($urandom % 6)
    0: return d1;
    1: return d2;
    2: return d3;
    default: return reg_idx_t'($urandom % 8);
  endcase
endfunction

function automatic word_t random_instr(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
  logic [11:0] imm;
  logic [11:0] offset;
  logic [19:0] upper;
  int unsigned kind;
  kind   = $urandom % 18;
  imm    = 12'($urandom);
  upper  = 20'($urandom);
  offset = {4'b0000, 6'($urandom), 2'b00};  // word inside the data window
  case (kind)
    0:  return encode_r(7'h00, rs2, rs1, 3'b000, rd);  // add
    1:  return encode_r(7'h20, rs2, rs1, 3'b000, rd);  // sub
    2:  return encode_r(7'h00, rs2, rs1, 3'b111, rd);
    3:  return encode_r(7'h00, rs2, rs1, 3'b110, rd);
    4:  return encode_r(7'h00, rs2, rs1, 3'b100, rd);
    5:  return encode_r(7'h00, rs2, rs1, 3'b001, rd);  // sll
    6:  return encode_i(imm, rs1, 3'b000, rd, op_imm);  // addi
    7:  return encode_i(imm, rs1, 3'b111, rd, op_imm);
    8:  return encode_i(imm, rs1, 3'b110, rd, op_imm);
    9:  return encode_i(imm, rs1, 3'b100, rd, op_imm);
    10: return encode_i({7'h00, imm[4:0]}, rs1, 3'b001, rd, op_imm);  // slli
    11: return {upper, rd, op_lui};
    12, 13: return encode_i(offset, 5'd0, 3'b010, rd, op_load);
    default: return encode_s(offset, rs2, 5'd0);
  endcase
endfunction

function automatic void build_program();
  reg_idx_t d1;
  reg_idx_t d2;
  reg_idx_t d3;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     prev_load;
  word_t    w;
  d1 = 5'd0;
  d2 = 5'd0;
  d3 = 5'd0;
  prev_load = 1'b0;
  for (int i = 0; i < 256; i++)
    imem[i] = nop_word;
  for (int i = 0; i < prog_len; i++)
  begin
    rd  = reg_idx_t'($urandom % 8);
    rs1 = pick_src(d1, d2, d3);
    rs2 = pick_src(d1, d2, d3);
    if (prev_load && ($urandom % 2 == 1))
    begin
      rs1 = d1;  // Load-use pair
      rs2 = d1;
    end
    w = random_instr(rd, rs1, rs2);
    imem[i] = w;
    d3 = d2;
    d2 = d1;
    d1 = (w[6:0] == op_store) ? 5'd0 : w[11:7];
    prev_load = (w[6:0] == op_load);
  end
endfunction

function automatic word_t expected_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b111:  return a & b;
    3'b110:  return a | b;
    3'b100:  return a ^ b;
    3'b001:  return a << b[4:0];
    default: return '0;
  endcase
endfunction

// Executes one instruction on the architectural state
function automatic void step_model(word_t w);
  logic [6:0] opcode;
  logic [2:0] f3;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_s;
  word_t      addr;
  word_t      res;
  logic       uses1;
  logic       uses2;
  opcode = w[6:0];
  rd     = w[11:7];
  f3     = w[14:12];
  rs1    = w[19:15];
  rs2    = w[24:20];
  a      = ref_regs[rs1];
  b      = ref_regs[rs2];
  imm_i  = {{20{w[31]}}, w[31:20]};
  imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
  uses1  = (opcode != op_lui);
  uses2  = (opcode == op_reg) || (opcode == op_store);
  if (last_load_rd != 5'd0 &&
      ((uses1 && rs1 == last_load_rd) || (uses2 && rs2 == last_load_rd)))
    exp_stalls++;
  last_load_rd = (opcode == op_load) ? rd : 5'd0;
  res = '0;
  case (opcode)
    op_reg:  res = expected_alu(f3, w[30], a, b);
    op_imm:  res = expected_alu(f3, 1'b0, a, imm_i);
    op_lui:  res = {w[31:12], 12'b0};
    op_load:
    begin
      addr = a + imm_i;
      res  = ref_mem[addr[7:2]];
    end
    op_store:
    begin
      addr = a + imm_s;
      ref_mem[addr[7:2]] = b;
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(b);
    end
    default: ;
  endcase
  if (opcode != op_store && rd != 5'd0)
    ref_regs[rd] = res;
endfunction

`endif

/* tests/tb_rv32_core.sv */
// Testbench for the five-stage RV32I core
// Clock, reset, instruction and data memories, random program
// Store comparison against the reference model, pc hold count, watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_rv32_core
  import rv32_pkg::*;
();

  localparam int    prog_len     = 200;
  localparam int    clk_period   = 20;
  localparam int    reset_cycles = 8;
  localparam word_t nop_word     = 32'h00000013;  // addi x0, x0, 0

  logic      clk;
  logic      reset;
  word_t     pc;
  word_t     inst;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  word_t     imem [0:255];
  word_t     dmem [0:63];
  word_t     ref_regs [0:31];
  word_t     ref_mem [0:63];
  word_t     exp_addr_q [$];
  word_t     exp_data_q [$];
  int        exp_stalls;
  reg_idx_t  last_load_rd;   // rd of the previous instruction if it loaded
  int        pc_repeats;
  word_t     last_pc;
  logic      run_done;
  word_t     exp_addr;
  word_t     exp_data;

  `include "tb_ref_model.svh"

  rv32_core rv32_core_i (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .inst       (inst),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  assign inst       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  // Initial data pattern that differs in every address bit
  function automatic word_t fill_word(int idx);
    return word_t'(idx + 1) * 32'h9e3779b9;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Data memory and store comparison
  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 64; i++)
        dmem[i] <= fill_word(i);
    end
    else if (dmem_req.write)
    begin
      dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
      assert (exp_addr_q.size() != 0)
      else abort_run("A store left the core after all expected stores were seen");
      exp_addr = exp_addr_q.pop_front();
      exp_data = exp_data_q.pop_front();
      assert (dmem_req.addr == exp_addr)
      else abort_run($sformatf("ERROR: dmem_req.addr = %h, expected %h",
                               dmem_req.addr, exp_addr));
      assert (dmem_req.wdata == exp_data)
      else abort_run($sformatf("ERROR: dmem_req.wdata = %h, expected %h",
                               dmem_req.wdata, exp_data));
    end
  end

  // pc either advances by 4 or holds for one load-use bubble
  always @(posedge clk)
  begin
    if (reset)
    begin
      pc_repeats <= 0;
      last_pc    <= 32'hffff_fffc;  // so the first fetch must be 0
    end
    else if (!run_done)
    begin
      assert (pc == last_pc || pc == last_pc + 32'd4)
      else abort_run($sformatf("ERROR: pc = %h, expected %h or %h",
                               pc, last_pc, last_pc + 32'd4));
      if (pc == last_pc)
        pc_repeats <= pc_repeats + 1;
      last_pc <= pc;
    end
  end

  initial
  begin
    reset        = 1'b1;
    run_done     = 1'b0;
    exp_stalls   = 0;
    last_load_rd = 5'd0;
    void'($urandom(11));
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    for (int i = 0; i < 64; i++)
      ref_mem[i] = fill_word(i);
    build_program();
    for (int i = 0; i < prog_len; i++)
      step_model(imem[i]);

    @(posedge clk);
    repeat (reset_cycles)
    begin
      @(negedge clk);
      assert (!dmem_req.write)
      else abort_run("The data write strobe was high during reset");
      assert (pc == '0)
      else abort_run($sformatf("ERROR: pc = %h during reset, expected 0", pc));
    end
    reset = 1'b0;

    // Nothing reaches the memory stage yet
    repeat (2)
    begin
      @(negedge clk);
      assert (!dmem_req.write)
      else abort_run("The data write strobe was high right after reset");
    end

    while (pc < 4 * (prog_len + 5))
      @(negedge clk);
    run_done = 1'b1;
    @(negedge clk);

    assert (exp_addr_q.size() == 0)
    else abort_run("Not all expected stores reached the data memory");
    assert (pc_repeats == exp_stalls)
    else abort_run($sformatf("ERROR: pc repeat count = %h, expected %h",
                             pc_repeats, exp_stalls));
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Watchdog
  initial
  begin
    #((2 * prog_len + 50) * clk_period);
    abort_run("Timeout: the stores did not complete before the watchdog expired");
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tests
common/rv32_pkg.sv
execute/alu.sv
execute/hazard_unit.sv
decode/instr_decoder.sv
decode/reg_file.sv
hdl/rv32_core.sv
tests/tb_rv32_core.sv

/* Makefile */
# Verilator simulation of the RV32I core testbench

VERILATOR ?= verilator
TOP       := tb_rv32_core
FILELIST  := tb.f
FLAGS     := --binary --timing
LINT_FLAGS := --lint-only --timing
OBJ_DIR   := obj_dir
LOG       := run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
